// File: Makefile
TOP := decodeStage_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

// File: compile.f
hw/rv32iPkg.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/branchTarget.sv
hw/decodeStage.sv
testbench/tbClock.sv
testbench/decodeStage_properties.sv
testbench/decodeStage_tb.sv

// File: hw/branchTarget.sv
`timescale 1ns/1ps

module branchTarget (
    input  rv32iPkg::branchOpE             branchOp_i,
    input  logic [rv32iPkg::dataWidth-1:0] pc_i,
    input  logic [rv32iPkg::dataWidth-1:0] imm_i,
    output logic [rv32iPkg::dataWidth-1:0] dest_o
);

    // size of one instruction in bytes
    localparam logic [rv32iPkg::dataWidth-1:0] instrBytes = 4;

    always_comb begin
        case (branchOp_i)
            rv32iPkg::brCond, rv32iPkg::brJal: begin
                dest_o = pc_i + imm_i;
            end
            // execute adds rs1 later
            rv32iPkg::brJalr: begin
                dest_o = imm_i;
            end
            // fall-through
            default: begin
                dest_o = pc_i + instrBytes;
            end
        endcase
    end

endmodule

// File: hw/decodeStage.sv
`timescale 1ns/1ps

module decodeStage #(
    parameter int regAddrWidth = 5
) (
    input  logic                           Clk,
    input  logic                           rstN_i,
    // from fetch
    input  logic [rv32iPkg::dataWidth-1:0] pc_i,
    input  logic [rv32iPkg::dataWidth-1:0] instr_i,
    // hazard unit levels
    input  logic                           stall_i,
    input  logic                           flush_i,
    // write-back port
    input  logic [regAddrWidth-1:0]        wbRdAddr_i,
    input  logic [rv32iPkg::dataWidth-1:0] wbRdData_i,
    input  logic                           wbRegWrEn_i,
    // decode pipeline register
    output logic [rv32iPkg::dataWidth-1:0] pc_o,
    output logic [rv32iPkg::dataWidth-1:0] pcDest_o,
    output rv32iPkg::aluSrcE               aluSrc_o,
    output rv32iPkg::aluOpE                aluOp_o,
    output rv32iPkg::branchOpE             branchOp_o,
    output logic                           branchFlag_o,
    output logic                           memWrEn_o,
    output logic                           memRdEn_o,
    output logic                           regWrEn_o,
    output logic                           memToReg_o,
    output logic                           jump_o,
    output rv32iPkg::memOpE                memOp_o,
    output logic [rv32iPkg::dataWidth-1:0] imm1_o,
    output logic [rv32iPkg::dataWidth-1:0] imm2_o,
    output logic [rv32iPkg::dataWidth-1:0] rs1Data_o,
    output logic [rv32iPkg::dataWidth-1:0] rs2Data_o,
    output logic [regAddrWidth-1:0]        rdAddr_o,
    output logic [regAddrWidth-1:0]        rs1Addr_o,
    output logic [regAddrWidth-1:0]        rs2Addr_o,
    output logic                           exception_o
);

    // ==================================================
    // decoder outputs, before the pipeline register
    // ==================================================
    logic [rv32iPkg::dataWidth-1:0] decImm1, decImm2, decDest;
    logic [regAddrWidth-1:0]        decRdAddr, decRs1Addr, decRs2Addr;
    rv32iPkg::aluSrcE               decAluSrc;
    rv32iPkg::aluOpE                decAluOp;
    rv32iPkg::branchOpE             decBranchOp;
    rv32iPkg::memOpE                decMemOp;
    logic decBranchFlag, decMemWrEn, decMemRdEn, decRegWrEn;
    logic decMemToReg, decJump, decException;

    instrDecoder #(
        .regAddrWidth (regAddrWidth)
    ) decoder (
        .instr_i      (instr_i),
        .pc_i         (pc_i),
        .imm1_o       (decImm1),
        .imm2_o       (decImm2),
        .rdAddr_o     (decRdAddr),
        .rs1Addr_o    (decRs1Addr),
        .rs2Addr_o    (decRs2Addr),
        .aluSrc_o     (decAluSrc),
        .aluOp_o      (decAluOp),
        .branchOp_o   (decBranchOp),
        .branchFlag_o (decBranchFlag),
        .memWrEn_o    (decMemWrEn),
        .memRdEn_o    (decMemRdEn),
        .regWrEn_o    (decRegWrEn),
        .memToReg_o   (decMemToReg),
        .jump_o       (decJump),
        .memOp_o      (decMemOp),
        .exception_o  (decException)
    );

    branchTarget target (
        .branchOp_i (decBranchOp),
        .pc_i       (pc_i),
        .imm_i      (decImm2),
        .dest_o     (decDest)
    );

    // read with the registered addresses
    regFile #(
        .regAddrWidth (regAddrWidth)
    ) registers (
        .Clk       (Clk),
        .rstN_i    (rstN_i),
        .rs1Addr_i (rs1Addr_o),
        .rs2Addr_i (rs2Addr_o),
        .rdAddr_i  (wbRdAddr_i),
        .rdData_i  (wbRdData_i),
        .rdWrEn_i  (wbRegWrEn_i),
        .rs1Data_o (rs1Data_o),
        .rs2Data_o (rs2Data_o)
    );

    // ==================================================
    // pipeline register
    // ==================================================
    always_ff @(posedge Clk) begin
        // flush looks like reset, a bubble with every control low
        if (!rstN_i || flush_i) begin
            pc_o         <= '0;
            pcDest_o     <= '0;
            aluSrc_o     <= rv32iPkg::srcRegReg;
            aluOp_o      <= rv32iPkg::aluAdd;
            branchOp_o   <= rv32iPkg::brNone;
            branchFlag_o <= 1'b0;
            memWrEn_o    <= 1'b0;
            memRdEn_o    <= 1'b0;
            regWrEn_o    <= 1'b0;
            memToReg_o   <= 1'b0;
            jump_o       <= 1'b0;
            memOp_o      <= rv32iPkg::memB;
            imm1_o       <= '0;
            imm2_o       <= '0;
            rdAddr_o     <= '0;
            rs1Addr_o    <= '0;
            rs2Addr_o    <= '0;
            exception_o  <= 1'b0;
        end else if (stall_i) begin
            // data fields hold, side effects dropped
            memWrEn_o  <= 1'b0;
            memRdEn_o  <= 1'b0;
            regWrEn_o  <= 1'b0;
            memToReg_o <= 1'b0;
            jump_o     <= 1'b0;
            memOp_o    <= rv32iPkg::memB;
            rdAddr_o   <= '0;
        end else begin
            pc_o         <= pc_i;
            pcDest_o     <= decDest;
            aluSrc_o     <= decAluSrc;
            aluOp_o      <= decAluOp;
            branchOp_o   <= decBranchOp;
            branchFlag_o <= decBranchFlag;
            memWrEn_o    <= decMemWrEn;
            memRdEn_o    <= decMemRdEn;
            regWrEn_o    <= decRegWrEn;
            memToReg_o   <= decMemToReg;
            jump_o       <= decJump;
            memOp_o      <= decMemOp;
            imm1_o       <= decImm1;
            imm2_o       <= decImm2;
            rdAddr_o     <= decRdAddr;
            rs1Addr_o    <= decRs1Addr;
            rs2Addr_o    <= decRs2Addr;
            exception_o  <= decException;
        end
    end

endmodule

// File: hw/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder #(
    parameter int regAddrWidth = 5
) (
    input  logic [rv32iPkg::dataWidth-1:0] instr_i,
    input  logic [rv32iPkg::dataWidth-1:0] pc_i,
    output logic [rv32iPkg::dataWidth-1:0] imm1_o,
    output logic [rv32iPkg::dataWidth-1:0] imm2_o,
    output logic [regAddrWidth-1:0]        rdAddr_o,
    output logic [regAddrWidth-1:0]        rs1Addr_o,
    output logic [regAddrWidth-1:0]        rs2Addr_o,
    output rv32iPkg::aluSrcE               aluSrc_o,
    output rv32iPkg::aluOpE                aluOp_o,
    output rv32iPkg::branchOpE             branchOp_o,
    output logic                           branchFlag_o,
    output logic                           memWrEn_o,
    output logic                           memRdEn_o,
    output logic                           regWrEn_o,
    output logic                           memToReg_o,
    output logic                           jump_o,
    output rv32iPkg::memOpE                memOp_o,
    output logic                           exception_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [rv32iPkg::dataWidth-1:0] immI, immS, immB, immU, immJ;
    // which register fields the instruction really names
    logic useRd, useRs1, useRs2;
    logic badOp;
    logic badReg;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // ==================================================
    // immediate formats, sign bit is instr[31]
    // ==================================================
    assign immI = {{20{instr_i[31]}}, instr_i[31:20]};
    assign immS = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign immB = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                   instr_i[11:8], 1'b0};
    assign immU = {instr_i[31:12], 12'b0};
    assign immJ = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                   instr_i[30:21], 1'b0};

    // raw fields, legality checked below
    assign rdAddr_o  = instr_i[7 +: regAddrWidth];
    assign rs1Addr_o = instr_i[15 +: regAddrWidth];
    assign rs2Addr_o = instr_i[20 +: regAddrWidth];

    always_comb begin
        imm1_o       = '0;
        imm2_o       = '0;
        aluSrc_o     = rv32iPkg::srcRegReg;
        aluOp_o      = rv32iPkg::aluAdd;
        branchOp_o   = rv32iPkg::brNone;
        branchFlag_o = 1'b0;
        memWrEn_o    = 1'b0;
        memRdEn_o    = 1'b0;
        regWrEn_o    = 1'b0;
        memToReg_o   = 1'b0;
        jump_o       = 1'b0;
        memOp_o      = rv32iPkg::memB;
        useRd        = 1'b0;
        useRs1       = 1'b0;
        useRs2       = 1'b0;
        badOp        = 1'b0;

        case (opcode)
            rv32iPkg::opLui: begin
                imm2_o    = immU;
                aluSrc_o  = rv32iPkg::srcRegImm;
                aluOp_o   = rv32iPkg::aluPassB;
                regWrEn_o = 1'b1;
                useRd     = 1'b1;
            end
            rv32iPkg::opAuipc: begin
                imm1_o    = pc_i;
                imm2_o    = immU;
                aluSrc_o  = rv32iPkg::srcPcImm;
                regWrEn_o = 1'b1;
                useRd     = 1'b1;
            end
            rv32iPkg::opJal, rv32iPkg::opJalr: begin
                imm1_o    = pc_i;
                aluSrc_o  = rv32iPkg::srcPcImm;
                regWrEn_o = 1'b1;
                jump_o    = 1'b1;
                useRd     = 1'b1;
                if (opcode == rv32iPkg::opJal) begin
                    imm2_o     = immJ;
                    branchOp_o = rv32iPkg::brJal;
                end else begin
                    imm2_o     = immI;
                    branchOp_o = rv32iPkg::brJalr;
                    useRs1     = 1'b1;
                    badOp      = (funct3 != 3'b000);
                end
            end
            rv32iPkg::opBranch: begin
                imm2_o       = immB;
                branchOp_o   = rv32iPkg::brCond;
                // bne, bge and bgeu invert the compare
                branchFlag_o = funct3[0];
                useRs1       = 1'b1;
                useRs2       = 1'b1;
                badOp        = (funct3[2:1] == 2'b01);
                case (funct3[2:1])
                    2'b10:   aluOp_o = rv32iPkg::aluSlt;
                    2'b11:   aluOp_o = rv32iPkg::aluSltu;
                    default: aluOp_o = rv32iPkg::aluSub;
                endcase
            end
            rv32iPkg::opLoad: begin
                imm2_o     = immI;
                aluSrc_o   = rv32iPkg::srcRegImm;
                memRdEn_o  = 1'b1;
                memToReg_o = 1'b1;
                regWrEn_o  = 1'b1;
                memOp_o    = rv32iPkg::memOpE'(funct3);
                useRd      = 1'b1;
                useRs1     = 1'b1;
                badOp      = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            end
            rv32iPkg::opStore: begin
                imm2_o    = immS;
                aluSrc_o  = rv32iPkg::srcRegImm;
                memWrEn_o = 1'b1;
                memOp_o   = rv32iPkg::memOpE'(funct3);
                useRs1    = 1'b1;
                useRs2    = 1'b1;
                badOp     = (funct3 > 3'b010);
            end
            rv32iPkg::opOp, rv32iPkg::opOpImm: begin
                regWrEn_o = 1'b1;
                useRd     = 1'b1;
                useRs1    = 1'b1;
                if (opcode == rv32iPkg::opOp) begin
                    useRs2 = 1'b1;
                end else begin
                    imm2_o   = immI;
                    aluSrc_o = rv32iPkg::srcRegImm;
                end
                case (funct3)
                    3'b000: begin
                        if (opcode == rv32iPkg::opOp && funct7[5]) begin
                            aluOp_o = rv32iPkg::aluSub;
                        end else begin
                            aluOp_o = rv32iPkg::aluAdd;
                        end
                    end
                    3'b001:  aluOp_o = rv32iPkg::aluSll;
                    3'b010:  aluOp_o = rv32iPkg::aluSlt;
                    3'b011:  aluOp_o = rv32iPkg::aluSltu;
                    3'b100:  aluOp_o = rv32iPkg::aluXor;
                    3'b101:  aluOp_o = funct7[5] ? rv32iPkg::aluSra : rv32iPkg::aluSrl;
                    3'b110:  aluOp_o = rv32iPkg::aluOr;
                    default: aluOp_o = rv32iPkg::aluAnd;
                endcase
                // funct7 is 0, or 0x20 for sub and sra only
                if (opcode == rv32iPkg::opOp || funct3 == 3'b001 || funct3 == 3'b101) begin
                    badOp = !(funct7 == 7'h00 || (funct7 == 7'h20 &&
                              ((funct3 == 3'b000 && opcode == rv32iPkg::opOp) ||
                               funct3 == 3'b101)));
                end
            end
            default: badOp = 1'b1;
        endcase

        // indices the smaller register file cannot hold
        badReg = (useRd  && ((instr_i[11:7]  >> regAddrWidth) != 5'd0)) ||
                 (useRs1 && ((instr_i[19:15] >> regAddrWidth) != 5'd0)) ||
                 (useRs2 && ((instr_i[24:20] >> regAddrWidth) != 5'd0));

        exception_o = badOp || badReg;
        if (exception_o) begin
            memWrEn_o    = 1'b0;
            memRdEn_o    = 1'b0;
            regWrEn_o    = 1'b0;
            memToReg_o   = 1'b0;
            jump_o       = 1'b0;
            branchOp_o   = rv32iPkg::brNone;
            branchFlag_o = 1'b0;
        end
    end

endmodule

// File: hw/regFile.sv
`timescale 1ns/1ps

module regFile #(
    parameter int regAddrWidth = 5
) (
    input  logic                           Clk,
    input  logic                           rstN_i,
    input  logic [regAddrWidth-1:0]        rs1Addr_i,
    input  logic [regAddrWidth-1:0]        rs2Addr_i,
    input  logic [regAddrWidth-1:0]        rdAddr_i,
    input  logic [rv32iPkg::dataWidth-1:0] rdData_i,
    input  logic                           rdWrEn_i,
    output logic [rv32iPkg::dataWidth-1:0] rs1Data_o,
    output logic [rv32iPkg::dataWidth-1:0] rs2Data_o
);

    localparam int depth = 2 ** regAddrWidth;

    logic [rv32iPkg::dataWidth-1:0] regs [depth];

    // single write port, x0 never written
    always_ff @(posedge Clk) begin
        if (!rstN_i) begin
            for (int i = 0; i < depth; i++) begin
                regs[i] <= '0;
            end
        end else if (rdWrEn_i && (rdAddr_i != '0)) begin
            regs[rdAddr_i] <= rdData_i;
        end
    end

    // combinational reads, no write bypass
    assign rs1Data_o = (rs1Addr_i == '0) ? '0 : regs[rs1Addr_i];
    assign rs2Data_o = (rs2Addr_i == '0) ? '0 : regs[rs2Addr_i];

endmodule

// File: hw/rv32iPkg.sv
package rv32iPkg;

    // pc, instruction and register data
    parameter int dataWidth = 32;

    // ==================================================
    // major opcodes, instr[6:0]
    // ==================================================
    parameter logic [6:0] opLui    = 7'b0110111;
    parameter logic [6:0] opAuipc  = 7'b0010111;
    parameter logic [6:0] opJal    = 7'b1101111;
    parameter logic [6:0] opJalr   = 7'b1100111;
    parameter logic [6:0] opBranch = 7'b1100011;
    parameter logic [6:0] opLoad   = 7'b0000011;
    parameter logic [6:0] opStore  = 7'b0100011;
    parameter logic [6:0] opOpImm  = 7'b0010011;
    parameter logic [6:0] opOp     = 7'b0110011;

    // alu operation, passB forwards operand 2 (lui)
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB
    } aluOpE;

    typedef enum logic [1:0] {
        brNone,
        brCond,
        brJal,
        brJalr
    } branchOpE;

    // operand select for the alu
    typedef enum logic [1:0] {
        srcRegReg,
        srcRegImm,
        srcPcImm
    } aluSrcE;

    // same code as funct3 of loads and stores
    typedef enum logic [2:0] {
        memB  = 3'b000,
        memH  = 3'b001,
        memW  = 3'b010,
        memBu = 3'b100,
        memHu = 3'b101
    } memOpE;

endpackage

// File: testbench/decodeStage_properties.sv
`timescale 1ns/1ps

module decodeStage_properties (
    input logic Clk,
    input logic rstN_i,
    input logic stall_i,
    input logic flush_i,
    input logic memWrEn_i,
    input logic memRdEn_i,
    input logic regWrEn_i,
    input logic memToReg_i,
    input logic jump_i,
    input logic exception_i
);

    int failCount = 0;
    logic anyEnable;

    assign anyEnable = memWrEn_i || memRdEn_i || regWrEn_i || memToReg_i || jump_i;

    // reset or flush leaves a bubble
    bubbleAfterClear: assert property (@(posedge Clk) (!rstN_i || flush_i) |=> !anyEnable)
        else begin
            failCount++;
            $error("enable set after a reset or flush cycle");
        end

    // a stalled stage must not write memory or registers
    noWriteInStall: assert property (@(posedge Clk)
        (rstN_i && !flush_i && stall_i) |=> (!memWrEn_i && !regWrEn_i))
        else begin
            failCount++;
            $error("write enable set after a stall cycle");
        end

    quietException: assert property (@(posedge Clk) disable iff (!rstN_i)
        exception_i |-> !anyEnable)
        else begin
            failCount++;
            $error("enable set together with exception");
        end

endmodule

bind decodeStage decodeStage_properties props (
    .Clk         (Clk),
    .rstN_i      (rstN_i),
    .stall_i     (stall_i),
    .flush_i     (flush_i),
    .memWrEn_i   (memWrEn_o),
    .memRdEn_i   (memRdEn_o),
    .regWrEn_i   (regWrEn_o),
    .memToReg_i  (memToReg_o),
    .jump_i      (jump_o),
    .exception_i (exception_o)
);

// File: testbench/decodeStage_tb.sv
`timescale 1ns/1ps

module decodeStage_tb;

    // enable bits in the order memWr, memRd, regWr, memToReg, jump
    localparam logic [4:0] enMemWr    = 5'b10000;
    localparam logic [4:0] enMemRd    = 5'b01000;
    localparam logic [4:0] enRegWr    = 5'b00100;
    localparam logic [4:0] enMemToReg = 5'b00010;
    localparam logic [4:0] enJump     = 5'b00001;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] pcDest;
        logic [31:0] imm1;
        logic [31:0] imm2;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [1:0]  aluSrc;
        logic [3:0]  aluOp;
        logic [1:0]  brOp;
        logic        brFlag;
        logic [4:0]  enables;
        logic [2:0]  memOp;
        logic        exc;
    } expT;

    logic Clk, rstN_i;
    logic [31:0] pc_i, instr_i, wbRdData_i;
    logic stall_i, flush_i, wbRegWrEn_i;
    logic [4:0] wbRdAddr_i;
    logic [31:0] pc_o, pcDest_o, imm1_o, imm2_o, rs1Data_o, rs2Data_o;
    rv32iPkg::aluSrcE aluSrc_o;
    rv32iPkg::aluOpE aluOp_o;
    rv32iPkg::branchOpE branchOp_o;
    rv32iPkg::memOpE memOp_o;
    logic branchFlag_o, memWrEn_o, memRdEn_o, regWrEn_o, memToReg_o, jump_o, exception_o;
    logic [4:0] rdAddr_o, rs1Addr_o, rs2Addr_o;

    int errors = 0;
    logic [31:0] lfsr = 32'h6e32fef4;
    string testName = "reset";
    string modelName = "reset";
    bit modelValid = 1'b0;
    expT model;
    logic [31:0] shadow [32];

    tbClock clockGen (
        .Clk    (Clk),
        .rstN_o (rstN_i)
    );

    decodeStage #(
        .regAddrWidth (5)
    ) DUT (.*);

    function automatic logic [31:0] galoisStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = galoisStep(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] legalInstr(input logic [3:0] cls, input logic [31:0] r);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = r[14:12];
        f7 = (r[30] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        case (cls)
            4'd0: return {r[31:7], rv32iPkg::opLui};
            4'd1: return {r[31:7], rv32iPkg::opAuipc};
            4'd2: return {r[31:7], rv32iPkg::opJal};
            4'd3: return {r[31:15], 3'b000, r[11:7], rv32iPkg::opJalr};
            // 010 and 011 are no branches
            4'd4: return {r[31:15], (f3[2:1] == 2'b01) ? {1'b1, f3[1:0]} : f3, r[11:7],
                          rv32iPkg::opBranch};
            4'd5: return {r[31:15], (f3 == 3'd3 || f3[2:1] == 2'b11) ? 3'd2 : f3, r[11:7],
                          rv32iPkg::opLoad};
            4'd6: return {r[31:15], (f3[1:0] == 2'b11) ? 3'b010 : {1'b0, f3[1:0]}, r[11:7],
                          rv32iPkg::opStore};
            4'd7: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    return {f7, r[24:15], f3, r[11:7], rv32iPkg::opOpImm};
                end
                return {r[31:15], f3, r[11:7], rv32iPkg::opOpImm};
            end
            default: return {f7, r[24:15], f3, r[11:7], rv32iPkg::opOp};
        endcase
    endfunction

    function automatic logic [31:0] illegalInstr(input logic [2:0] cls, input logic [31:0] r);
        case (cls)
            3'd0: return {r[31:7], 7'b1110011};
            3'd1: return {r[31:7], 7'b0001111};
            3'd2: return {r[31:15], 3'b001, r[11:7], rv32iPkg::opJalr};
            3'd3: return {r[31:15], 3'b010, r[11:7], rv32iPkg::opBranch};
            3'd4: return {r[31:15], 3'b011, r[11:7], rv32iPkg::opLoad};
            3'd5: return {r[31:15], 3'b100, r[11:7], rv32iPkg::opStore};
            // multiply is not part of rv32i
            3'd6: return {7'h01, r[24:15], 3'b000, r[11:7], rv32iPkg::opOp};
            default: return {7'h20, r[24:15], 3'b001, r[11:7], rv32iPkg::opOpImm};
        endcase
    endfunction

    function automatic logic [31:0] randPc();
        return takeBits(32) & 32'hFFFF_FFFC;
    endfunction

    function automatic logic [31:0] randLegal();
        return legalInstr(4'(takeBits(4) % 9), takeBits(32));
    endfunction

    // ==================================================
    // reference decoder
    // ==================================================
    function automatic expT refDecode(input logic [31:0] ins, input logic [31:0] pc);
        expT e;
        logic [2:0] f3;
        logic [6:0] f7;
        logic isOp;
        logic [31:0] immI, immS, immB, immU, immJ;
        f3 = ins[14:12];
        f7 = ins[31:25];
        isOp = (ins[6:0] == rv32iPkg::opOp);
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immU = {ins[31:12], 12'h000};
        immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        e = '0;
        e.pc = pc;
        e.rd = ins[11:7];
        e.rs1 = ins[19:15];
        e.rs2 = ins[24:20];
        case (ins[6:0])
            rv32iPkg::opLui: begin
                e.imm2 = immU;
                e.aluSrc = rv32iPkg::srcRegImm;
                e.aluOp = rv32iPkg::aluPassB;
                e.enables = enRegWr;
            end
            rv32iPkg::opAuipc: begin
                e.imm1 = pc;
                e.imm2 = immU;
                e.aluSrc = rv32iPkg::srcPcImm;
                e.enables = enRegWr;
            end
            rv32iPkg::opJal, rv32iPkg::opJalr: begin
                e.imm1 = pc;
                e.aluSrc = rv32iPkg::srcPcImm;
                e.enables = enRegWr | enJump;
                e.imm2 = (ins[6:0] == rv32iPkg::opJal) ? immJ : immI;
                e.brOp = (ins[6:0] == rv32iPkg::opJal) ? rv32iPkg::brJal : rv32iPkg::brJalr;
                e.exc = (ins[6:0] == rv32iPkg::opJalr) && (f3 != 3'd0);
            end
            rv32iPkg::opBranch: begin
                e.imm2 = immB;
                e.brOp = rv32iPkg::brCond;
                e.brFlag = f3[0];
                e.aluOp = f3[2] ? (f3[1] ? rv32iPkg::aluSltu : rv32iPkg::aluSlt)
                                : rv32iPkg::aluSub;
                e.exc = (f3 == 3'd2) || (f3 == 3'd3);
            end
            rv32iPkg::opLoad: begin
                e.imm2 = immI;
                e.aluSrc = rv32iPkg::srcRegImm;
                e.enables = enMemRd | enMemToReg | enRegWr;
                e.memOp = f3;
                e.exc = !(f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
            end
            rv32iPkg::opStore: begin
                e.imm2 = immS;
                e.aluSrc = rv32iPkg::srcRegImm;
                e.enables = enMemWr;
                e.memOp = f3;
                e.exc = (f3 > 3'd2);
            end
            rv32iPkg::opOp, rv32iPkg::opOpImm: begin
                e.enables = enRegWr;
                e.imm2 = isOp ? 32'd0 : immI;
                e.aluSrc = isOp ? rv32iPkg::srcRegReg : rv32iPkg::srcRegImm;
                case (f3)
                    3'd0: e.aluOp = (isOp && f7[5]) ? rv32iPkg::aluSub : rv32iPkg::aluAdd;
                    3'd1: e.aluOp = rv32iPkg::aluSll;
                    3'd2: e.aluOp = rv32iPkg::aluSlt;
                    3'd3: e.aluOp = rv32iPkg::aluSltu;
                    3'd4: e.aluOp = rv32iPkg::aluXor;
                    3'd5: e.aluOp = f7[5] ? rv32iPkg::aluSra : rv32iPkg::aluSrl;
                    3'd6: e.aluOp = rv32iPkg::aluOr;
                    default: e.aluOp = rv32iPkg::aluAnd;
                endcase
                // only sub, sra and srai may set funct7 to 0x20
                if (isOp || f3 == 3'd1 || f3 == 3'd5) begin
                    e.exc = !(f7 == 7'h00 ||
                              (f7 == 7'h20 && (f3 == 3'd5 || (isOp && f3 == 3'd0))));
                end
            end
            default: e.exc = 1'b1;
        endcase
        if (e.exc) begin
            e.enables = '0;
            e.brOp = rv32iPkg::brNone;
            e.brFlag = 1'b0;
        end
        case (e.brOp)
            rv32iPkg::brCond, rv32iPkg::brJal: e.pcDest = pc + e.imm2;
            rv32iPkg::brJalr: e.pcDest = e.imm2;
            default: e.pcDest = pc + 32'd4;
        endcase
        return e;
    endfunction

    task automatic check(input string testNm, input string field,
                         input logic [63:0] expVal, input logic [63:0] actVal);
        if (actVal !== expVal) begin
            errors++;
            $display("ERROR %s %s: expected %h, actual %h", testNm, field, expVal, actVal);
        end
    endtask

    task automatic drive(input string name, input logic [31:0] ins, input logic [31:0] pc,
                         input logic stall, input logic flush);
        @(posedge Clk);
        testName <= name;
        instr_i <= ins;
        pc_i <= pc;
        stall_i <= stall;
        flush_i <= flush;
        wbRegWrEn_i <= 1'b0;
    endtask

    task automatic writeBack(input logic [4:0] addr, input logic [31:0] data);
        @(posedge Clk);
        testName <= "register";
        wbRdAddr_i <= addr;
        wbRdData_i <= data;
        wbRegWrEn_i <= 1'b1;
    endtask

    // ==================================================
    // model of the pipeline register and register file
    // ==================================================
    always @(posedge Clk) begin
        modelValid = 1'b1;
        modelName = testName;
        if (!rstN_i || flush_i) begin
            model = '0;
        end else if (stall_i) begin
            model.enables = '0;
            model.memOp = '0;
            model.rd = '0;
        end else begin
            model = refDecode(instr_i, pc_i);
        end
        if (!rstN_i) begin
            foreach (shadow[i]) begin
                shadow[i] = '0;
            end
        end else if (wbRegWrEn_i && wbRdAddr_i != 5'd0) begin
            shadow[wbRdAddr_i] = wbRdData_i;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge Clk) begin
        if (modelValid) begin
            check(modelName, "pc", {model.pc, model.pcDest}, {pc_o, pcDest_o});
            check(modelName, "imm", {model.imm1, model.imm2}, {imm1_o, imm2_o});
            check(modelName, "regAddr", 64'({model.rd, model.rs1, model.rs2}),
                  64'({rdAddr_o, rs1Addr_o, rs2Addr_o}));
            check(modelName, "control",
                  64'({model.aluSrc, model.aluOp, model.brOp, model.brFlag, model.memOp,
                       model.exc}),
                  64'({aluSrc_o, aluOp_o, branchOp_o, branchFlag_o, memOp_o, exception_o}));
            check(modelName, "enables", 64'(model.enables),
                  64'({memWrEn_o, memRdEn_o, regWrEn_o, memToReg_o, jump_o}));
            check(modelName, "rsData", {shadow[model.rs1], shadow[model.rs2]},
                  {rs1Data_o, rs2Data_o});
        end
    end

    initial begin
        int waitCnt;
        int total;
        pc_i = '0;
        instr_i = 32'h00000013;
        stall_i = 1'b0;
        flush_i = 1'b0;
        wbRdAddr_i = '0;
        wbRdData_i = '0;
        wbRegWrEn_i = 1'b0;
        waitCnt = 0;
        while (rstN_i !== 1'b1 && waitCnt < 20) begin
            @(posedge Clk);
            waitCnt++;
        end
        if (rstN_i !== 1'b1) begin
            $display("timeout: reset was never released");
            $display("** FAIL **");
            $finish;
        end else begin
            for (int i = 0; i < 300; i++) begin
                drive("legal", randLegal(), randPc(), 1'b0, 1'b0);
            end
            for (int i = 0; i < 40; i++) begin
                drive("illegal", illegalInstr(3'(takeBits(3)), takeBits(32)), randPc(),
                      1'b0, 1'b0);
            end
            // every eighth write aims at x0
            for (int i = 0; i < 40; i++) begin
                writeBack((i % 8 == 0) ? 5'd0 : 5'(takeBits(5)), takeBits(32));
            end
            for (int r = 0; r < 32; r++) begin
                drive("register", {7'h00, 5'(31 - r), 5'(r), 3'b000, 5'd1, rv32iPkg::opOp},
                      randPc(), 1'b0, 1'b0);
            end
            drive("stall", legalInstr(4'd5, takeBits(32)), randPc(), 1'b0, 1'b0);
            for (int i = 0; i < 4; i++) begin
                drive("stall", randLegal(), randPc(), 1'b1, 1'b0);
            end
            drive("stall", randLegal(), randPc(), 1'b0, 1'b0);
            drive("flush", legalInstr(4'd2, takeBits(32)), randPc(), 1'b0, 1'b0);
            drive("flush", randLegal(), randPc(), 1'b1, 1'b1);
            drive("flush", randLegal(), randPc(), 1'b0, 1'b0);
            for (int i = 0; i < 200; i++) begin
                drive("mixed", randLegal(), randPc(),
                      takeBits(2) == 32'd0, takeBits(4) == 32'd0);
            end
            // last sample shows one edge later
            repeat (2) @(posedge Clk);
            total = errors + DUT.props.failCount;
            $display("compare errors: %0d, assertion failures: %0d",
                     errors, DUT.props.failCount);
            if (total == 0) begin
                $display("** PASS **");
            end else begin
                $display("** FAIL **");
            end
            $finish;
        end
    end

endmodule

// File: testbench/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic Clk,
    output logic rstN_o
);

    // 10 ns period
    initial begin
        Clk = 1'b0;
        forever begin
            #5 Clk = ~Clk;
        end
    end

    // reset low for the first 8 rising edges
    initial begin
        rstN_o = 1'b0;
        repeat (8) @(posedge Clk);
        rstN_o <= 1'b1;
    end

endmodule
